/* compile.f */
+incdir+src
src/cpu_pkg.sv
src/ctrl_if.sv
src/control_decoder.sv
src/register_file.sv
src/execute_unit.sv
src/memory_stage.sv
src/fetch_unit.sv
src/cpu_top.sv
test/cpu_properties.sv
test/cpu_tb.sv

/* Makefile */
TOP = cpu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

run: compile
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

/* test/cpu_tb.sv */
// cpu_tb runs directed tests of the single-cycle processor through its load and I/O ports
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;
  import cpu_pkg::*;

  localparam int n_words        = 17;  // io_out words over all tests
  localparam int reset_phases   = 7;   // six loads and one restart
  localparam int timeout_cycles = 64 * n_words + reset_phases * 20;

  logic        clk;
  logic        reset;
  logic        prog_we;
  logic [7:0]  prog_addr;
  logic [15:0] prog_data;
  logic [15:0] io_in;
  logic [15:0] io_out;
  logic        io_out_valid;

  logic [31:0] lfsr = 32'h6eb7_3c27;
  logic [15:0] prog [$];
  logic [15:0] expected [$];

  cpu_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(timeout_cycles * 100);
    $display("Timeout after %0d cycles, io_out words still missing", timeout_cycles);
    $display("STATUS: FAIL");
    $fatal(1);
  end

  initial begin
    wait (i_dut.i_props.n_fail != 0);
    $display("Assertion in cpu_properties failed at %0t ns", $time);
    $display("STATUS: FAIL");
    $fatal(1);
  end

  function automatic logic [15:0] lfsr_bits(input int n);
    logic [15:0] r;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r = {r[14:0], lfsr[0]};
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
    end
    return r;
  endfunction

  function automatic logic [15:0] encode(input opcode_e op, input logic [3:0] a,
                                         input logic [3:0] b, input logic [3:0] c);
    return {op, a, b, c};
  endfunction

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] want);
    if (got !== want) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
      $display("STATUS: FAIL");
      $fatal(1);
    end
  endtask

  task automatic load_program();
    int n;
    int i;
    n = (prog.size() > 10) ? prog.size() : 10;  // reset stays high at least 10 cycles
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      reset     <= 1'b1;
      prog_we   <= i < prog.size();
      prog_addr <= 8'(i);
      prog_data <= (i < prog.size()) ? prog[i] : 16'h0000;
    end
  endtask

  task automatic release_reset(input logic [15:0] first, input logic [15:0] second);
    @(posedge clk);
    reset   <= 1'b0;
    prog_we <= 1'b0;
    io_in   <= first;   // seen by the instruction at pc 0
    @(posedge clk);
    io_in   <= second;  // seen at pc 1
  endtask

  task automatic collect_outputs();
    while (expected.size() > 0) begin
      @(negedge clk);
      if (io_out_valid) compare("io_out", io_out, expected.pop_front());
    end
  endtask

  task automatic run_program(input logic [15:0] first, input logic [15:0] second);
    prog.push_back(encode(op_jal, 4'd0, 4'd0, 4'd0));  // jump to itself
    load_program();
    release_reset(first, second);
    collect_outputs();
    prog.delete();
  endtask

  // result into r3 and out through wri
  task automatic emit_result(input opcode_e op, input logic [3:0] b, input logic [3:0] c,
                             input logic [15:0] value);
    prog.push_back(encode(op, 4'd3, b, c));
    prog.push_back(encode(op_wri, 4'd0, 4'd3, 4'd0));
    expected.push_back(value);
  endtask

  task automatic arith_ops();
    logic [15:0] x;
    logic [15:0] y;
    x = lfsr_bits(16);
    y = lfsr_bits(16);
    prog = '{encode(op_rea, 4'd1, 4'd0, 4'd0), encode(op_rea, 4'd2, 4'd0, 4'd0)};
    emit_result(op_add, 4'd1, 4'd2, x + y);
    emit_result(op_sub, 4'd1, 4'd2, x - y);
    emit_result(op_grt, 4'd1, 4'd2, {15'd0, x > y});  // unsigned
    emit_result(op_eq, 4'd1, 4'd2, {15'd0, x == y});
    emit_result(op_addi, 4'd1, 4'hb, x + 16'hfffb);   // c is -5
    emit_result(op_lui, 4'ha, 4'h5, 16'ha500);
    run_program(x, y);
  endtask

  task automatic memory_roundtrip();
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] hi;
    x  = lfsr_bits(16);
    y  = lfsr_bits(16);
    hi = lfsr_bits(8);
    prog = '{encode(op_rea, 4'd1, 4'd0, 4'd0), encode(op_rea, 4'd2, 4'd0, 4'd0),
             encode(op_lui, 4'd3, hi[7:4], hi[3:0]), encode(op_addi, 4'd4, 4'd0, 4'd5),
             encode(op_sw, 4'd1, 4'd4, 4'd0), encode(op_sw, 4'd2, 4'd4, 4'd1),
             encode(op_sw, 4'd3, 4'd4, 4'he),  // base 5 minus 2
             encode(op_lw, 4'd5, 4'd4, 4'he), encode(op_wri, 4'd0, 4'd5, 4'd0),
             encode(op_lw, 4'd6, 4'd4, 4'd1), encode(op_wri, 4'd0, 4'd6, 4'd0),
             encode(op_lw, 4'd7, 4'd4, 4'd0), encode(op_wri, 4'd0, 4'd7, 4'd0)};
    expected = '{{hi[7:0], 8'h00}, y, x};
    run_program(x, y);
  endtask

  task automatic branch_paths();
    logic [15:0] x;
    logic [15:0] y;
    x = lfsr_bits(16);
    y = lfsr_bits(16);
    if (y == x) y = ~x;
    prog = '{encode(op_rea, 4'd1, 4'd0, 4'd0), encode(op_rea, 4'd2, 4'd0, 4'd0),
             encode(op_addi, 4'd3, 4'd1, 4'd0),
             encode(op_bne, 4'd3, 4'd1, 4'd3),  // equal operands fall through to pc 4
             encode(op_addi, 4'd5, 4'd0, 4'd1), encode(op_wri, 4'd0, 4'd5, 4'd0),
             encode(op_bne, 4'd2, 4'd1, 4'd3),  // unequal operands go on to pc 9
             encode(op_addi, 4'd5, 4'd0, 4'd2), encode(op_wri, 4'd0, 4'd5, 4'd0),
             encode(op_addi, 4'd5, 4'd0, 4'd3), encode(op_wri, 4'd0, 4'd5, 4'd0)};
    expected = '{16'd1, 16'd3};
    run_program(x, y);
  endtask

  task automatic jump_links();
    prog = '{encode(op_jal, 4'd1, 4'd0, 4'd4),   // pc 0 to pc 4
             encode(op_wri, 4'd0, 4'd2, 4'd0),   // return point of the jalr
             encode(op_jal, 4'd0, 4'd0, 4'd0),
             encode(op_wri, 4'd0, 4'd0, 4'd0),   // never reached
             encode(op_wri, 4'd0, 4'd1, 4'd0),
             encode(op_jalr, 4'd2, 4'd1, 4'd0)}; // pc 5 back to r1
    expected = '{16'd1, 16'd6};
    run_program(lfsr_bits(16), lfsr_bits(16));
  endtask

  task automatic zero_register();
    logic [15:0] x;
    x = lfsr_bits(16) | 16'h0001;
    prog = '{encode(op_rea, 4'd0, 4'd0, 4'd0), encode(op_addi, 4'd0, 4'd0, 4'd7),
             encode(op_lui, 4'd0, 4'hf, 4'hf), encode(op_wri, 4'd0, 4'd0, 4'd0)};
    expected = '{16'd0};
    run_program(x, lfsr_bits(16));
  endtask

  task automatic reset_restart();
    logic [15:0] x;
    logic [15:0] y;
    x = lfsr_bits(16);
    y = lfsr_bits(16);
    prog = '{encode(op_rea, 4'd1, 4'd0, 4'd0), encode(op_wri, 4'd0, 4'd1, 4'd0),
             encode(op_addi, 4'd2, 4'd1, 4'd1), encode(op_wri, 4'd0, 4'd2, 4'd0)};
    expected = '{x};
    run_program(x, y);
    @(posedge clk);
    reset <= 1'b1;  // the wri at pc 3 falls in reset
    repeat (10) begin
      @(negedge clk);
      compare("io_out_valid", {15'd0, io_out_valid}, 16'h0000);
    end
    expected = '{x, x + 16'd1};
    release_reset(x, y);
    collect_outputs();
  endtask

  initial begin
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = 8'h00;
    prog_data = 16'h0000;
    io_in     = 16'h0000;
    arith_ops();
    memory_roundtrip();
    branch_paths();
    jump_links();
    zero_register();
    reset_restart();
    if (i_dut.i_props.n_fail != 0) begin
      $display("%0d assertion failures in cpu_properties", i_dut.i_props.n_fail);
      $display("STATUS: FAIL");
      $fatal(1);
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* test/cpu_properties.sv */
// cpu_properties: reset and register zero assertions bound into the processor top level
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module cpu_properties (
  input logic        clk,
  input logic        reset,
  input logic        io_out_valid,
  input logic [7:0]  pc,
  input logic [3:0]  rs1_addr,
  input logic [15:0] rs1_data
);

  int n_fail = 0;  // failed assertions so far

  assert property (@(posedge clk) $fell(reset) |-> !io_out_valid)
    else begin
      $error("io_out_valid high in the first cycle after reset");
      n_fail++;
    end

  assert property (@(posedge clk) reset |=> pc == `CPU_RESET_PC)
    else begin
      $error("pc not at its reset value during reset");
      n_fail++;
    end

  assert property (@(posedge clk) disable iff (reset) rs1_addr == 4'd0 |-> rs1_data == '0)
    else begin
      $error("r0 read as nonzero");
      n_fail++;
    end

endmodule

bind cpu_top cpu_properties i_props (
  .clk(clk), .reset(reset), .io_out_valid(io_out_valid), .pc(pc),
  .rs1_addr(instr[7:4]), .rs1_data(rs1_data)
);

`default_nettype wire

/* src/cpu_top.sv */
// cpu_top: single-cycle 16-bit processor with program load and I/O ports
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module cpu_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 prog_we,
  input  logic [7:0]           prog_addr,
  input  logic [`CPU_XLEN-1:0] prog_data,
  input  logic [`CPU_XLEN-1:0] io_in,
  output logic [`CPU_XLEN-1:0] io_out,
  output logic                 io_out_valid
);
  import cpu_pkg::*;

  opcode_e              instr_op;
  logic [7:0]           pc;
  logic [7:0]           next_pc;
  logic [7:0]           link;
  logic [`CPU_XLEN-1:0] instr;
  logic [3:0]           rs2_addr;
  logic [`CPU_XLEN-1:0] rs1_data;
  logic [`CPU_XLEN-1:0] rs2_data;
  logic [`CPU_XLEN-1:0] alu_result;
  logic [`CPU_XLEN-1:0] wb_data;

  ctrl_if ctrl ();

  assign instr_op = opcode_e'(instr[15:12]);
  assign rs2_addr = ctrl.rs2_sel ? instr[11:8] : instr[3:0];  // ra for sw and bne
  assign link     = pc + 8'd1;

  control_decoder i_decoder (.instr_op(instr_op), .reset(reset), .ctrl(ctrl));

  fetch_unit i_fetch (
    .clk(clk), .reset(reset), .next_pc(next_pc), .prog_we(prog_we),
    .prog_addr(prog_addr), .prog_data(prog_data), .pc(pc), .instr(instr)
  );

  register_file i_regs (
    .clk(clk), .reset(reset), .rs1_addr(instr[7:4]), .rs2_addr(rs2_addr),
    .rd_addr(instr[11:8]), .rd_data(wb_data), .ctrl(ctrl),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  execute_unit i_exec (
    .instr(instr), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .ctrl(ctrl), .alu_result(alu_result), .next_pc(next_pc)
  );

  memory_stage i_mem (
    .clk(clk), .reset(reset), .addr(alu_result[7:0]), .store_data(rs2_data),
    .alu_result(alu_result), .io_in(io_in), .link(link), .ctrl(ctrl),
    .rd_data(wb_data), .io_out(io_out), .io_out_valid(io_out_valid)
  );

endmodule

`default_nettype wire

/* src/fetch_unit.sv */
// fetch_unit: program counter and instruction memory with a load port
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module fetch_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [7:0]           next_pc,
  input  logic                 prog_we,
  input  logic [7:0]           prog_addr,
  input  logic [`CPU_XLEN-1:0] prog_data,
  output logic [7:0]           pc,
  output logic [`CPU_XLEN-1:0] instr
);

  logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (reset) pc <= `CPU_RESET_PC;
    else pc <= next_pc;
  end

  // the loader may write at any time, also in reset
  always_ff @(posedge clk) begin
    if (prog_we) imem[prog_addr] <= prog_data;
  end

  assign instr = imem[pc];  // asynchronous read

endmodule

`default_nettype wire

/* src/memory_stage.sv */
// memory_stage: data RAM, I/O port and write-back selection
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module memory_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [7:0]           addr,
  input  logic [`CPU_XLEN-1:0] store_data,
  input  logic [`CPU_XLEN-1:0] alu_result,
  input  logic [`CPU_XLEN-1:0] io_in,
  input  logic [7:0]           link,
  ctrl_if.datapath             ctrl,
  output logic [`CPU_XLEN-1:0] rd_data,
  output logic [`CPU_XLEN-1:0] io_out,
  output logic                 io_out_valid
);
  import cpu_pkg::*;

  logic [`CPU_XLEN-1:0] dmem [`CPU_DMEM_DEPTH];

  always_ff @(posedge clk) begin
    if (ctrl.mem_write) dmem[addr] <= store_data;
    if (ctrl.io_write) io_out <= alu_result;
  end

  always_ff @(posedge clk) begin
    if (reset) io_out_valid <= 1'b0;
    else io_out_valid <= ctrl.io_write;  // single cycle pulse
  end

  always_comb begin
    case (ctrl.wb_sel)
      wb_mem:  rd_data = dmem[addr];
      wb_link: rd_data = {8'h00, link};
      wb_io:   rd_data = io_in;
      default: rd_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

/* src/execute_unit.sv */
// execute_unit: immediate generation, operand selection, ALU and next PC
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module execute_unit (
  input  logic [`CPU_XLEN-1:0] instr,
  input  logic [7:0]           pc,
  input  logic [`CPU_XLEN-1:0] rs1_data,
  input  logic [`CPU_XLEN-1:0] rs2_data,
  ctrl_if.datapath             ctrl,
  output logic [`CPU_XLEN-1:0] alu_result,
  output logic [7:0]           next_pc
);
  import cpu_pkg::*;

  logic [`CPU_XLEN-1:0] imm;
  logic [`CPU_XLEN-1:0] op_a;
  logic [`CPU_XLEN-1:0] op_b;
  logic [7:0]           pc_plus1;
  logic                 taken;

  always_comb begin
    case (ctrl.imm_sel)
      imm_c4:  imm = {{12{instr[3]}}, instr[3:0]};
      imm_s8:  imm = {{8{instr[7]}}, instr[7:0]};
      imm_lui: imm = {instr[7:0], 8'h00};
      default: imm = '0;
    endcase
  end

  assign op_a = (ctrl.imm_sel == imm_lui) ? '0 : rs1_data;  // lui adds to zero
  assign op_b = (ctrl.src_b_sel == src_b_imm) ? imm : rs2_data;

  always_comb begin
    alu_result = '0;
    case (ctrl.alu_op)
      alu_add: alu_result = op_a + op_b;
      alu_sub: alu_result = op_a - op_b;
      alu_gt:  alu_result[0] = op_a > op_b;   // unsigned
      alu_eq:  alu_result[0] = op_a == op_b;
      default: alu_result = '0;
    endcase
  end

  assign pc_plus1 = pc + 8'd1;
  assign taken    = rs1_data != rs2_data;

  always_comb begin
    case (ctrl.pc_sel)
      pc_branch: next_pc = taken ? pc + imm[7:0] : pc_plus1;
      pc_jal:    next_pc = pc + imm[7:0];
      pc_jalr:   next_pc = rs1_data[7:0] + imm[7:0];
      default:   next_pc = pc_plus1;
    endcase
  end

endmodule

`default_nettype wire

/* src/register_file.sv */
// register_file: sixteen general registers, two read ports and one write port
`timescale 1ns/1ns
`default_nettype none
`include "cpu_macros.svh"

module register_file (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [3:0]           rs1_addr,
  input  logic [3:0]           rs2_addr,
  input  logic [3:0]           rd_addr,
  input  logic [`CPU_XLEN-1:0] rd_data,
  ctrl_if.datapath             ctrl,
  output logic [`CPU_XLEN-1:0] rs1_data,
  output logic [`CPU_XLEN-1:0] rs2_data
);

  logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_write && rd_addr != 4'd0) begin  // r0 stays zero
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

/* src/control_decoder.sv */
// control_decoder: maps the opcode onto the control fields of one instruction
`timescale 1ns/1ns
`default_nettype none

module control_decoder (
  input  cpu_pkg::opcode_e instr_op,
  input  logic             reset,
  ctrl_if.decoder          ctrl
);
  import cpu_pkg::*;

  always_comb begin
    ctrl.imm_sel   = imm_c4;
    ctrl.alu_op    = alu_add;
    ctrl.src_b_sel = src_b_reg;
    ctrl.rs2_sel   = 1'b0;
    ctrl.wb_sel    = wb_alu;
    ctrl.pc_sel    = pc_next;
    ctrl.reg_write = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.io_write  = 1'b0;
    case (instr_op)
      op_add: ctrl.reg_write = 1'b1;
      op_sub: begin
        ctrl.alu_op    = alu_sub;
        ctrl.reg_write = 1'b1;
      end
      op_grt: begin
        ctrl.alu_op    = alu_gt;
        ctrl.reg_write = 1'b1;
      end
      op_eq: begin
        ctrl.alu_op    = alu_eq;
        ctrl.reg_write = 1'b1;
      end
      op_addi: begin
        ctrl.src_b_sel = src_b_imm;
        ctrl.reg_write = 1'b1;
      end
      op_lui: begin
        ctrl.imm_sel   = imm_lui;   // operand a forced to zero downstream
        ctrl.src_b_sel = src_b_imm;
        ctrl.reg_write = 1'b1;
      end
      op_lw: begin
        ctrl.src_b_sel = src_b_imm;
        ctrl.wb_sel    = wb_mem;
        ctrl.reg_write = 1'b1;
      end
      op_sw: begin
        ctrl.src_b_sel = src_b_imm;
        ctrl.rs2_sel   = 1'b1;     // store data from ra
        ctrl.mem_write = 1'b1;
      end
      op_jal: begin
        ctrl.imm_sel   = imm_s8;
        ctrl.wb_sel    = wb_link;
        ctrl.pc_sel    = pc_jal;
        ctrl.reg_write = 1'b1;
      end
      op_jalr: begin
        ctrl.wb_sel    = wb_link;
        ctrl.pc_sel    = pc_jalr;
        ctrl.reg_write = 1'b1;
      end
      op_bne: begin
        ctrl.rs2_sel = 1'b1;       // compare rb with ra
        ctrl.pc_sel  = pc_branch;
      end
      op_wri: begin
        ctrl.src_b_sel = src_b_imm;  // rb plus field c, plain use has c zero
        ctrl.io_write  = 1'b1;
      end
      default: begin             // rea
        ctrl.wb_sel    = wb_io;
        ctrl.reg_write = 1'b1;
      end
    endcase
    if (reset) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.io_write  = 1'b0;
      ctrl.pc_sel    = pc_next;
    end
  end

endmodule

`default_nettype wire

/* src/ctrl_if.sv */
// ctrl_if: decoded control fields passed from the decoder to the datapath
`timescale 1ns/1ns
`default_nettype none

interface ctrl_if;
  import cpu_pkg::*;

  imm_sel_e   imm_sel;
  alu_op_e    alu_op;
  src_b_sel_e src_b_sel;
  logic       rs2_sel;   // 0 field c, 1 field a
  wb_sel_e    wb_sel;
  pc_sel_e    pc_sel;
  logic       reg_write;
  logic       mem_write;
  logic       io_write;

  modport decoder (output imm_sel, alu_op, src_b_sel, rs2_sel, wb_sel, pc_sel,
                   reg_write, mem_write, io_write);

  modport datapath (input imm_sel, alu_op, src_b_sel, rs2_sel, wb_sel, pc_sel,
                    reg_write, mem_write, io_write);
endinterface

`default_nettype wire

/* src/cpu_pkg.sv */
// cpu_pkg: opcode and decoded control field types of the processor
`default_nettype none

package cpu_pkg;

  typedef enum logic [3:0] {
    op_add  = 4'b0000,
    op_grt  = 4'b0001,
    op_sub  = 4'b0010,
    op_eq   = 4'b0011,
    op_jalr = 4'b0100,
    op_lui  = 4'b0101,
    op_jal  = 4'b0110,
    op_addi = 4'b1000,
    op_lw   = 4'b1001,
    op_sw   = 4'b1010,
    op_bne  = 4'b1011,
    op_wri  = 4'b1100,
    op_rea  = 4'b1111   // also taken by every unlisted code
  } opcode_e;

  typedef enum logic [1:0] {imm_c4, imm_s8, imm_lui} imm_sel_e;
  typedef enum logic [1:0] {alu_add, alu_sub, alu_gt, alu_eq} alu_op_e;
  typedef enum logic {src_b_reg, src_b_imm} src_b_sel_e;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_link, wb_io} wb_sel_e;
  typedef enum logic [1:0] {pc_next, pc_branch, pc_jal, pc_jalr} pc_sel_e;

endpackage

`default_nettype wire

/* src/cpu_macros.svh */
// cpu_macros: widths, sizes and reset values shared by the processor blocks
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and instruction width
`define CPU_XLEN 16

`define CPU_NREGS 16

// both memories are word addressed by the low 8 bits of an address
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

`define CPU_RESET_PC 8'd0

`endif
